//--- hdl/cpu_pkg.sv
package cpu_pkg;

  // Default widths for the execute subsystem
  localparam int DATA_W_DEF = 32;
  localparam int REG_N_DEF  = 8;

  // Status word layout
  localparam int STAT_W  = 7;
  localparam int STAT_CF = 0;
  localparam int STAT_PF = 1;
  localparam int STAT_ZF = 2;
  localparam int STAT_SF = 3;
  localparam int STAT_OF = 4;
  localparam int STAT_AF = 5;
  localparam int STAT_DF = 6;

  // Command opcodes as seen at the subsystem boundary
  typedef enum logic [4:0] {
    CMD_MOV  = 5'd0,
    CMD_ADD  = 5'd1,
    CMD_ADC  = 5'd2,
    CMD_SUB  = 5'd3,
    CMD_SBB  = 5'd4,
    CMD_CMP  = 5'd5,
    CMD_AND  = 5'd6,
    CMD_OR   = 5'd7,
    CMD_XOR  = 5'd8,
    CMD_TEST = 5'd9,
    CMD_NOT  = 5'd10,
    CMD_INC  = 5'd11,
    CMD_DEC  = 5'd12,
    CMD_MUL  = 5'd13,
    CMD_DIV  = 5'd14,
    CMD_SHL  = 5'd15,
    CMD_SHR  = 5'd16,
    CMD_ROL  = 5'd17,
    CMD_ROR  = 5'd18,
    CMD_STD  = 5'd19,
    CMD_CLD  = 5'd20
  } cmd_e;

  // Operations the ALU datapath knows about
  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_MUL = 4'd5,
    ALU_DIV = 4'd6,
    ALU_SHL = 4'd7,
    ALU_SHR = 4'd8,
    ALU_ROL = 4'd9,
    ALU_ROR = 4'd10
  } alu_op_e;

endpackage

//--- hdl/cmd_decode.sv
`timescale 1ns/100ps

module cmd_decode (
  input  cpu_pkg::cmd_e    cmd,
  output cpu_pkg::alu_op_e alu_op,
  output logic             use_carry,
  output logic             no_wr,
  output logic             no_flags,
  output logic             keep_cf,
  output logic             clear_cf_of,
  output logic             src_one,
  output logic             src_inv,
  output logic             is_mov,
  output logic             df_set,
  output logic             df_clr
);
  import cpu_pkg::*;

  always_comb begin
    alu_op      = ALU_ADD;
    use_carry   = 1'b0;
    no_wr       = 1'b0;
    no_flags    = 1'b0;
    keep_cf     = 1'b0;
    clear_cf_of = 1'b0;
    src_one     = 1'b0;
    src_inv     = 1'b0;
    is_mov      = 1'b0;
    df_set      = 1'b0;
    df_clr      = 1'b0;

    case (cmd)
      CMD_MOV: begin
        no_flags = 1'b1;
        is_mov   = 1'b1;
      end
      CMD_ADD: alu_op = ALU_ADD;
      CMD_ADC: begin
        alu_op    = ALU_ADD;
        use_carry = 1'b1;
      end
      CMD_SUB: alu_op = ALU_SUB;
      CMD_SBB: begin
        alu_op    = ALU_SUB;
        use_carry = 1'b1;
      end
      // Flags only, result is dropped
      CMD_CMP: begin
        alu_op = ALU_SUB;
        no_wr  = 1'b1;
      end
      CMD_AND: begin
        alu_op      = ALU_AND;
        clear_cf_of = 1'b1;
      end
      CMD_OR: begin
        alu_op      = ALU_OR;
        clear_cf_of = 1'b1;
      end
      CMD_XOR: begin
        alu_op      = ALU_XOR;
        clear_cf_of = 1'b1;
      end
      CMD_TEST: begin
        alu_op      = ALU_AND;
        no_wr       = 1'b1;
        clear_cf_of = 1'b1;
      end
      // XOR against all ones, flags untouched
      CMD_NOT: begin
        alu_op   = ALU_XOR;
        no_flags = 1'b1;
        src_inv  = 1'b1;
      end
      CMD_INC: begin
        alu_op  = ALU_ADD;
        src_one = 1'b1;
        keep_cf = 1'b1;
      end
      CMD_DEC: begin
        alu_op  = ALU_SUB;
        src_one = 1'b1;
        keep_cf = 1'b1;
      end
      CMD_MUL: alu_op = ALU_MUL;
      CMD_DIV: alu_op = ALU_DIV;
      CMD_SHL: begin
        alu_op      = ALU_SHL;
        clear_cf_of = 1'b1;
      end
      CMD_SHR: begin
        alu_op      = ALU_SHR;
        clear_cf_of = 1'b1;
      end
      CMD_ROL: begin
        alu_op      = ALU_ROL;
        clear_cf_of = 1'b1;
      end
      CMD_ROR: begin
        alu_op      = ALU_ROR;
        clear_cf_of = 1'b1;
      end
      CMD_STD: begin
        no_flags = 1'b1;
        df_set   = 1'b1;
      end
      CMD_CLD: begin
        no_flags = 1'b1;
        df_clr   = 1'b1;
      end
      // Unused encodings behave as a no-op
      default: begin
        no_flags = 1'b1;
        no_wr    = 1'b1;
      end
    endcase
  end

endmodule

//--- hdl/alu.sv
`timescale 1ns/100ps

module alu #(
  parameter int DATA_W = cpu_pkg::DATA_W_DEF
) (
  input  cpu_pkg::alu_op_e           alu_op,
  input  logic                       use_carry,
  input  logic                       no_wr,
  input  logic                       no_flags,
  input  logic                       keep_cf,
  input  logic                       clear_cf_of,
  input  logic [cpu_pkg::STAT_W-1:0] status_in,
  input  logic [DATA_W-1:0]          opnd0,
  input  logic [DATA_W-1:0]          opnd1,
  output logic [DATA_W-1:0]          result,
  output logic [cpu_pkg::STAT_W-1:0] status_out
);
  import cpu_pkg::*;

  localparam int SH_W = $clog2(DATA_W);

  logic                carry_in;
  logic [DATA_W:0]     sum_ext;
  logic [DATA_W:0]     diff_ext;
  logic [2*DATA_W-1:0] prod;
  logic [DATA_W-1:0]   quot;
  logic [SH_W-1:0]     shamt;
  logic [2*DATA_W-1:0] rol_ext;
  logic [2*DATA_W-1:0] ror_ext;
  logic                carry;
  logic                ovf;
  logic                is_arith;
  logic                upd;
  logic                hold_cf;

  // Carry in only when the command asks for it
  assign carry_in = use_carry & status_in[STAT_CF];

  // Top bit of the difference is the borrow
  assign sum_ext  = {1'b0, opnd0} + {1'b0, opnd1} + {{DATA_W{1'b0}}, carry_in};
  assign diff_ext = {1'b0, opnd0} - {1'b0, opnd1} - {{DATA_W{1'b0}}, carry_in};

  assign prod  = {{DATA_W{1'b0}}, opnd0} * {{DATA_W{1'b0}}, opnd1};
  assign quot  = (opnd1 == '0) ? '1 : opnd0 / opnd1;

  // Rotates via a doubled operand
  assign shamt   = opnd1[SH_W-1:0];
  assign rol_ext = {opnd0, opnd0} << shamt;
  assign ror_ext = {opnd0, opnd0} >> shamt;

  always_comb begin
    result   = '0;
    carry    = 1'b0;
    ovf      = 1'b0;
    is_arith = 1'b0;
    case (alu_op)
      ALU_ADD: begin
        result   = sum_ext[DATA_W-1:0];
        carry    = sum_ext[DATA_W];
        ovf      = (opnd0[DATA_W-1] == opnd1[DATA_W-1]) &&
                   (result[DATA_W-1] != opnd0[DATA_W-1]);
        is_arith = 1'b1;
      end
      ALU_SUB: begin
        result   = diff_ext[DATA_W-1:0];
        carry    = diff_ext[DATA_W];
        ovf      = (opnd0[DATA_W-1] != opnd1[DATA_W-1]) &&
                   (result[DATA_W-1] != opnd0[DATA_W-1]);
        is_arith = 1'b1;
      end
      ALU_AND: result = opnd0 & opnd1;
      ALU_OR:  result = opnd0 | opnd1;
      ALU_XOR: result = opnd0 ^ opnd1;
      ALU_MUL: begin
        result = prod[DATA_W-1:0];
        carry  = |prod[2*DATA_W-1:DATA_W];
        ovf    = |prod[2*DATA_W-1:DATA_W];
      end
      ALU_DIV: result = quot;
      ALU_SHL: result = opnd0 << shamt;
      ALU_SHR: result = opnd0 >> shamt;
      ALU_ROL: result = rol_ext[2*DATA_W-1:DATA_W];
      ALU_ROR: result = ror_ext[DATA_W-1:0];
      default: result = '0;
    endcase
  end

  // Flags-only commands always refresh every arithmetic flag, CF included
  assign upd     = ~no_flags;
  assign hold_cf = ~upd | (keep_cf & ~no_wr);

  always_comb begin
    status_out = status_in;
    if (upd) begin
      status_out[STAT_PF] = ~^result[7:0];
      status_out[STAT_ZF] = (result == '0);
      status_out[STAT_SF] = result[DATA_W-1];
      status_out[STAT_OF] = clear_cf_of ? 1'b0 : ovf;
      status_out[STAT_AF] = is_arith & (opnd0[4] ^ opnd1[4] ^ result[4]);
    end
    if (!hold_cf) begin
      status_out[STAT_CF] = clear_cf_of ? 1'b0 : carry;
    end
    // DF is owned by the execute stage
    status_out[STAT_DF] = status_in[STAT_DF];
  end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/100ps

module reg_file #(
  parameter int DATA_W = cpu_pkg::DATA_W_DEF,
  parameter int REG_N  = cpu_pkg::REG_N_DEF
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic [$clog2(REG_N)-1:0] rd0_addr,
  input  logic [$clog2(REG_N)-1:0] rd1_addr,
  output logic [DATA_W-1:0]        rd0_data,
  output logic [DATA_W-1:0]        rd1_data,
  input  logic                     wr_en,
  input  logic [$clog2(REG_N)-1:0] wr_addr,
  input  logic [DATA_W-1:0]        wr_data
);

  logic [DATA_W-1:0] regs [REG_N];

  // General registers come up as zero
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < REG_N; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Read ports see the write only after the edge
  assign rd0_data = regs[rd0_addr];
  assign rd1_data = regs[rd1_addr];

  a_wr_addr_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    wr_en |-> !$isunknown(wr_addr)
  ) else $error("reg_file write with unknown address");

endmodule

//--- hdl/execute.sv
`timescale 1ns/100ps

module execute #(
  parameter int DATA_W = cpu_pkg::DATA_W_DEF,
  parameter int REG_N  = cpu_pkg::REG_N_DEF
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       cmd_valid,
  input  logic [$clog2(REG_N)-1:0]   dst,
  input  logic [$clog2(REG_N)-1:0]   src,
  input  logic [DATA_W-1:0]          imm,
  input  logic                       use_imm,
  input  logic                       no_wr,
  input  logic                       src_one,
  input  logic                       src_inv,
  input  logic                       is_mov,
  input  logic                       df_set,
  input  logic                       df_clr,
  output logic [$clog2(REG_N)-1:0]   rd0_addr,
  output logic [$clog2(REG_N)-1:0]   rd1_addr,
  input  logic [DATA_W-1:0]          rd0_data,
  input  logic [DATA_W-1:0]          rd1_data,
  output logic                       wr_en,
  output logic [$clog2(REG_N)-1:0]   wr_addr,
  output logic [DATA_W-1:0]          wr_data,
  output logic [DATA_W-1:0]          opnd0,
  output logic [DATA_W-1:0]          opnd1,
  input  logic [DATA_W-1:0]          alu_result,
  input  logic [cpu_pkg::STAT_W-1:0] alu_status,
  output logic [cpu_pkg::STAT_W-1:0] status_q,
  output logic                       done,
  output logic [DATA_W-1:0]          result,
  output logic                       wr,
  output logic [cpu_pkg::STAT_W-1:0] status
);
  import cpu_pkg::*;

  logic [DATA_W-1:0] src_val;
  logic [DATA_W-1:0] result_nxt;
  logic [STAT_W-1:0] status_nxt;

  // Destination doubles as the first operand
  assign rd0_addr = dst;
  assign rd1_addr = src;
  assign opnd0    = rd0_data;

  assign src_val = use_imm ? imm : rd1_data;

  always_comb begin
    if (src_inv) begin
      opnd1 = '1;
    end else if (src_one) begin
      opnd1 = {{(DATA_W-1){1'b0}}, 1'b1};
    end else begin
      opnd1 = src_val;
    end
  end

  // MOV bypasses the ALU result
  assign result_nxt = is_mov ? opnd1 : alu_result;

  assign wr_en   = cmd_valid & ~no_wr & ~df_set & ~df_clr;
  assign wr_addr = dst;
  assign wr_data = result_nxt;

  always_comb begin
    status_nxt = alu_status;
    if (df_set) begin
      status_nxt[STAT_DF] = 1'b1;
    end
    if (df_clr) begin
      status_nxt[STAT_DF] = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done     <= 1'b0;
      wr       <= 1'b0;
      status_q <= '0;
    end else begin
      done <= cmd_valid;
      wr   <= wr_en;
      if (cmd_valid) begin
        status_q <= status_nxt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      result <= result_nxt;
    end
  end

  // Flags seen by the next command and by the outside are the same register
  assign status = status_q;

  a_done_follows: assert property (
    @(posedge clk) disable iff (!arst_n)
    cmd_valid |=> done
  ) else $error("done missing one cycle after cmd_valid");

  a_done_only: assert property (
    @(posedge clk) disable iff (!arst_n)
    !cmd_valid |=> !done
  ) else $error("done without a command");

  a_no_wr_cmp: assert property (
    @(posedge clk) disable iff (!arst_n)
    (cmd_valid && no_wr) |=> !wr
  ) else $error("wr raised for a flags-only command");

endmodule

//--- hdl/exec_unit.sv
`timescale 1ns/100ps

module exec_unit #(
  parameter int DATA_W = cpu_pkg::DATA_W_DEF,
  parameter int REG_N  = cpu_pkg::REG_N_DEF
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       cmd_valid,
  input  cpu_pkg::cmd_e              cmd,
  input  logic [$clog2(REG_N)-1:0]   dst,
  input  logic [$clog2(REG_N)-1:0]   src,
  input  logic [DATA_W-1:0]          imm,
  input  logic                       use_imm,
  output logic                       done,
  output logic [DATA_W-1:0]          result,
  output logic                       wr,
  output logic [cpu_pkg::STAT_W-1:0] status
);
  import cpu_pkg::*;

  localparam int AW = $clog2(REG_N);

  alu_op_e           alu_op;
  logic              use_carry;
  logic              no_wr;
  logic              no_flags;
  logic              keep_cf;
  logic              clear_cf_of;
  logic              src_one;
  logic              src_inv;
  logic              is_mov;
  logic              df_set;
  logic              df_clr;
  logic [AW-1:0]     rd0_addr;
  logic [AW-1:0]     rd1_addr;
  logic [DATA_W-1:0] rd0_data;
  logic [DATA_W-1:0] rd1_data;
  logic              wr_en;
  logic [AW-1:0]     wr_addr;
  logic [DATA_W-1:0] wr_data;
  logic [DATA_W-1:0] opnd0;
  logic [DATA_W-1:0] opnd1;
  logic [DATA_W-1:0] alu_result;
  logic [STAT_W-1:0] alu_status;
  logic [STAT_W-1:0] status_q;

  cmd_decode decode_i (
    .cmd         (cmd),
    .alu_op      (alu_op),
    .use_carry   (use_carry),
    .no_wr       (no_wr),
    .no_flags    (no_flags),
    .keep_cf     (keep_cf),
    .clear_cf_of (clear_cf_of),
    .src_one     (src_one),
    .src_inv     (src_inv),
    .is_mov      (is_mov),
    .df_set      (df_set),
    .df_clr      (df_clr)
  );

  alu #(
    .DATA_W (DATA_W)
  ) alu_i (
    .alu_op      (alu_op),
    .use_carry   (use_carry),
    .no_wr       (no_wr),
    .no_flags    (no_flags),
    .keep_cf     (keep_cf),
    .clear_cf_of (clear_cf_of),
    .status_in   (status_q),
    .opnd0       (opnd0),
    .opnd1       (opnd1),
    .result      (alu_result),
    .status_out  (alu_status)
  );

  reg_file #(
    .DATA_W (DATA_W),
    .REG_N  (REG_N)
  ) regs_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .rd0_addr (rd0_addr),
    .rd1_addr (rd1_addr),
    .rd0_data (rd0_data),
    .rd1_data (rd1_data),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  execute #(
    .DATA_W (DATA_W),
    .REG_N  (REG_N)
  ) execute_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .cmd_valid  (cmd_valid),
    .dst        (dst),
    .src        (src),
    .imm        (imm),
    .use_imm    (use_imm),
    .no_wr      (no_wr),
    .src_one    (src_one),
    .src_inv    (src_inv),
    .is_mov     (is_mov),
    .df_set     (df_set),
    .df_clr     (df_clr),
    .rd0_addr   (rd0_addr),
    .rd1_addr   (rd1_addr),
    .rd0_data   (rd0_data),
    .rd1_data   (rd1_data),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .opnd0      (opnd0),
    .opnd1      (opnd1),
    .alu_result (alu_result),
    .alu_status (alu_status),
    .status_q   (status_q),
    .done       (done),
    .result     (result),
    .wr         (wr),
    .status     (status)
  );

endmodule

//--- tests/tb_exec_unit.sv
`timescale 1ns/100ps

module tb_exec_unit;
  import cpu_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int AW         = $clog2(REG_N_DEF);
  localparam int STREAM_N   = 200;
  // Upper bound on commands issued by all tests together
  localparam int CMD_BUDGET = 400;
  localparam int WATCHDOG_CYCLES = CMD_BUDGET * 8 + 200;

  logic              clk;
  logic              arst_n;
  logic              cmd_valid;
  cmd_e              cmd;
  logic [AW-1:0]     dst;
  logic [AW-1:0]     src;
  logic [31:0]       imm;
  logic              use_imm;
  logic              done;
  logic [31:0]       result;
  logic              wr;
  logic [STAT_W-1:0] status;

  // Reference state mirrored from the flag rules
  logic [31:0]       m_regs [REG_N_DEF];
  logic [STAT_W-1:0] m_status;
  logic [31:0]       lfsr_state;
  int                checks;
  int                errors;

  exec_unit dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .dst       (dst),
    .src       (src),
    .imm       (imm),
    .use_imm   (use_imm),
    .done      (done),
    .result    (result),
    .wr        (wr),
    .status    (status)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("test failed");
    $finish;
  end

  // Galois LFSR, one step per bit
  function automatic logic next_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic reset_model();
    for (int i = 0; i < REG_N_DEF; i++) begin
      m_regs[i] = '0;
    end
    m_status = '0;
  endtask

  // Expected response of one command, state updated in order
  task automatic run_model(input cmd_e c, input logic [AW-1:0] d, input logic [AW-1:0] s,
                           input logic [31:0] im, input logic ui, output logic [31:0] r,
                           output logic w, output logic [STAT_W-1:0] st, output logic chk_r);
    logic [31:0] a;
    logic [31:0] b;
    logic [63:0] wide;
    longint      sres;
    logic        cin;
    logic        cf;
    logic        of_flag;
    logic        arith;
    logic        upd_flags;
    logic        upd_cf;
    int          sh;
    a = m_regs[d];
    b = ui ? im : m_regs[s];
    st = m_status;
    r = '0;
    w = 1'b1;
    chk_r = 1'b1;
    cf = 1'b0;
    of_flag = 1'b0;
    arith = 1'b0;
    upd_flags = 1'b1;
    upd_cf = 1'b1;
    sh = int'(b[4:0]);
    if (c == CMD_INC || c == CMD_DEC) begin
      b = 32'd1;
    end
    cin = (c == CMD_ADC || c == CMD_SBB) ? m_status[STAT_CF] : 1'b0;
    case (c)
      CMD_MOV: begin
        r = b;
        upd_flags = 1'b0;
      end
      CMD_ADD, CMD_ADC, CMD_INC: begin
        wide = {32'd0, a} + {32'd0, b} + {63'd0, cin};
        sres = longint'($signed(a)) + longint'($signed(b)) + longint'(cin);
        r = wide[31:0];
        cf = wide[32];
        of_flag = (sres > 64'sd2147483647) || (sres < -64'sd2147483648);
        arith = 1'b1;
        upd_cf = (c != CMD_INC);
      end
      CMD_SUB, CMD_SBB, CMD_CMP, CMD_DEC: begin
        wide = {32'd0, a} - {32'd0, b} - {63'd0, cin};
        sres = longint'($signed(a)) - longint'($signed(b)) - longint'(cin);
        r = wide[31:0];
        cf = ({32'd0, a} < ({32'd0, b} + {63'd0, cin}));
        of_flag = (sres > 64'sd2147483647) || (sres < -64'sd2147483648);
        arith = 1'b1;
        w = (c != CMD_CMP);
        upd_cf = (c != CMD_DEC);
      end
      CMD_AND, CMD_TEST: begin
        r = a & b;
        w = (c != CMD_TEST);
      end
      CMD_OR:  r = a | b;
      CMD_XOR: r = a ^ b;
      CMD_NOT: begin
        r = ~a;
        upd_flags = 1'b0;
      end
      CMD_MUL: begin
        wide = {32'd0, a} * {32'd0, b};
        r = wide[31:0];
        cf = (wide[63:32] != 32'd0);
        of_flag = cf;
      end
      CMD_DIV: r = (b == 32'd0) ? 32'hFFFF_FFFF : a / b;
      CMD_SHL: r = a << sh;
      CMD_SHR: r = a >> sh;
      CMD_ROL: r = (a << sh) | (a >> (32 - sh));
      CMD_ROR: r = (a >> sh) | (a << (32 - sh));
      CMD_STD, CMD_CLD: begin
        upd_flags = 1'b0;
        w = 1'b0;
        chk_r = 1'b0;
        st[STAT_DF] = (c == CMD_STD);
      end
      default: begin
        upd_flags = 1'b0;
        w = 1'b0;
        chk_r = 1'b0;
      end
    endcase
    if (upd_flags) begin
      st[STAT_PF] = ~^r[7:0];
      st[STAT_ZF] = (r == 32'd0);
      st[STAT_SF] = r[31];
      st[STAT_OF] = of_flag;
      st[STAT_AF] = arith & (a[4] ^ b[4] ^ r[4]);
      if (upd_cf) begin
        st[STAT_CF] = cf;
      end
    end
    if (w) begin
      m_regs[d] = r;
    end
    m_status = st;
  endtask

  task automatic check_response(input string tag, input logic [31:0] er, input logic ew,
                                input logic [STAT_W-1:0] es, input logic chk_r);
    compare({tag, " wr"}, 32'(wr), 32'(ew));
    compare({tag, " status"}, 32'(status), 32'(es));
    if (chk_r) begin
      compare({tag, " result"}, result, er);
    end
  endtask

  // One command on its own, then wait for done
  task automatic issue(input cmd_e c, input logic [AW-1:0] d, input logic [AW-1:0] s,
                       input logic [31:0] im, input logic ui);
    logic [31:0]       er;
    logic              ew;
    logic [STAT_W-1:0] es;
    logic              ec;
    int                waited;
    run_model(c, d, s, im, ui, er, ew, es, ec);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd       <= c;
    dst       <= d;
    src       <= s;
    imm       <= im;
    use_imm   <= ui;
    @(posedge clk);
    cmd_valid <= 1'b0;
    waited = 1;
    @(negedge clk);
    while (done !== 1'b1 && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    if (done !== 1'b1) begin
      errors++;
      $display("No done pulse for command %s at %0t ns", c.name(), $time);
    end else begin
      compare({c.name(), " done latency"}, 32'(waited), 32'd1);
      check_response(c.name(), er, ew, es, ec);
    end
  endtask

  task automatic add_sub_flags();
    logic [31:0] vals [REG_N_DEF];
    vals[0] = 32'h7FFF_FFFF;
    vals[1] = 32'h0000_0001;
    vals[2] = 32'h8000_0000;
    vals[3] = 32'hFFFF_FFFF;
    for (int i = 4; i < REG_N_DEF; i++) begin
      vals[i] = rand_bits(32);
    end
    for (int i = 0; i < REG_N_DEF; i++) begin
      issue(CMD_MOV, AW'(i), 3'd0, vals[i], 1'b1);
    end
    // Signed overflow, carry out, most negative minus one, borrow
    issue(CMD_ADD, 3'd0, 3'd1, 32'd0, 1'b0);
    issue(CMD_ADD, 3'd3, 3'd1, 32'd0, 1'b0);
    issue(CMD_SUB, 3'd2, 3'd1, 32'd0, 1'b0);
    issue(CMD_SUB, 3'd1, 3'd0, 32'h0000_0010, 1'b1);
    for (int i = 4; i < REG_N_DEF; i++) begin
      issue(CMD_ADD, AW'(i), AW'(i - 4), 32'd0, 1'b0);
      issue(CMD_SUB, AW'(i - 4), AW'(i), 32'd0, 1'b0);
    end
    // Nibble carry and nibble borrow
    issue(CMD_MOV, 3'd6, 3'd0, 32'h0000_000F, 1'b1);
    issue(CMD_ADD, 3'd6, 3'd0, 32'h0000_0001, 1'b1);
    issue(CMD_SUB, 3'd6, 3'd0, 32'h0000_0001, 1'b1);
  endtask

  task automatic carry_and_compare();
    // CF set, then consumed by ADC
    issue(CMD_MOV, 3'd0, 3'd0, 32'hFFFF_FFFF, 1'b1);
    issue(CMD_ADD, 3'd0, 3'd0, 32'd1, 1'b1);
    issue(CMD_MOV, 3'd1, 3'd0, 32'h0000_0010, 1'b1);
    issue(CMD_ADC, 3'd1, 3'd0, 32'd5, 1'b1);
    issue(CMD_ADC, 3'd1, 3'd0, 32'd5, 1'b1);
    // Borrow set, then consumed by SBB
    issue(CMD_MOV, 3'd2, 3'd0, 32'd0, 1'b1);
    issue(CMD_SUB, 3'd2, 3'd0, 32'd1, 1'b1);
    issue(CMD_MOV, 3'd3, 3'd0, 32'd100, 1'b1);
    issue(CMD_SBB, 3'd3, 3'd0, 32'd10, 1'b1);
    issue(CMD_SBB, 3'd3, 3'd0, 32'd10, 1'b1);
    issue(CMD_SUB, 3'd2, 3'd0, 32'hFFFF_FFFF, 1'b1);
    issue(CMD_MOV, 3'd4, 3'd0, 32'h8000_0000, 1'b1);
    // Borrow taken from the most negative value overflows
    issue(CMD_CMP, 3'd3, 3'd0, 32'd100, 1'b1);
    issue(CMD_SBB, 3'd4, 3'd0, 32'd0, 1'b1);
    // Flags only, destination must survive
    issue(CMD_MOV, 3'd5, 3'd0, 32'd42, 1'b1);
    issue(CMD_CMP, 3'd5, 3'd0, 32'd42, 1'b1);
    issue(CMD_CMP, 3'd5, 3'd0, 32'd100, 1'b1);
    issue(CMD_MOV, 3'd6, 3'd5, 32'd0, 1'b0);
    issue(CMD_TEST, 3'd5, 3'd0, 32'h0000_0000, 1'b1);
    issue(CMD_TEST, 3'd5, 3'd0, 32'h0000_0020, 1'b1);
    issue(CMD_MOV, 3'd7, 3'd5, 32'd0, 1'b0);
  endtask

  task automatic inc_dec_logic();
    cmd_e logic_ops [3];
    logic_ops = '{CMD_AND, CMD_OR, CMD_XOR};
    issue(CMD_MOV, 3'd0, 3'd0, 32'd0, 1'b1);
    issue(CMD_SUB, 3'd0, 3'd0, 32'd1, 1'b1);
    issue(CMD_INC, 3'd0, 3'd0, 32'd0, 1'b1);
    issue(CMD_DEC, 3'd0, 3'd0, 32'd0, 1'b1);
    issue(CMD_MOV, 3'd1, 3'd0, 32'h7FFF_FFFF, 1'b1);
    issue(CMD_INC, 3'd1, 3'd0, 32'd0, 1'b1);
    issue(CMD_DEC, 3'd1, 3'd0, 32'd0, 1'b1);
    // Same boundaries with CF clear
    issue(CMD_ADD, 3'd2, 3'd0, 32'd0, 1'b1);
    issue(CMD_INC, 3'd1, 3'd0, 32'd0, 1'b1);
    issue(CMD_DEC, 3'd1, 3'd0, 32'd0, 1'b1);
    issue(CMD_MOV, 3'd4, 3'd0, rand_bits(32), 1'b1);
    for (int i = 0; i < 3; i++) begin
      // 0x80000000 doubled leaves both CF and OF set
      issue(CMD_MOV, 3'd3, 3'd0, 32'h8000_0000, 1'b1);
      issue(CMD_ADD, 3'd3, 3'd3, 32'd0, 1'b0);
      issue(CMD_NOT, 3'd4, 3'd0, 32'd0, 1'b1);
      issue(logic_ops[i], 3'd4, 3'd0, rand_bits(32), 1'b1);
    end
  endtask

  task automatic shift_mul_div();
    cmd_e        sh_ops [4];
    logic [31:0] amts [6];
    sh_ops = '{CMD_SHL, CMD_SHR, CMD_ROL, CMD_ROR};
    amts = '{32'd0, 32'd1, 32'd31, 32'd32, 32'd33, 32'hFFFF_FFE1};
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 6; j++) begin
        issue(CMD_MOV, 3'd1, 3'd0, 32'h8000_0013, 1'b1);
        issue(sh_ops[i], 3'd1, 3'd0, amts[j], 1'b1);
      end
    end
    // Amount taken from a register
    issue(CMD_MOV, 3'd2, 3'd0, 32'd35, 1'b1);
    issue(CMD_MOV, 3'd1, 3'd0, 32'hF000_000F, 1'b1);
    issue(CMD_ROL, 3'd1, 3'd2, 32'd0, 1'b0);
    issue(CMD_SHR, 3'd1, 3'd2, 32'd0, 1'b0);
    issue(CMD_MOV, 3'd3, 3'd0, 32'h0000_1234, 1'b1);
    issue(CMD_MUL, 3'd3, 3'd0, 32'h0000_0010, 1'b1);
    issue(CMD_MOV, 3'd3, 3'd0, 32'h0001_0000, 1'b1);
    issue(CMD_MUL, 3'd3, 3'd0, 32'h0001_0000, 1'b1);
    issue(CMD_MOV, 3'd3, 3'd0, 32'hFFFF_FFFF, 1'b1);
    issue(CMD_MUL, 3'd3, 3'd3, 32'd0, 1'b0);
    issue(CMD_MOV, 3'd4, 3'd0, 32'd100, 1'b1);
    issue(CMD_DIV, 3'd4, 3'd0, 32'd7, 1'b1);
    issue(CMD_MOV, 3'd4, 3'd0, 32'h8000_0000, 1'b1);
    issue(CMD_CMP, 3'd4, 3'd0, 32'hFFFF_FFFF, 1'b1);
    issue(CMD_DIV, 3'd4, 3'd0, 32'd0, 1'b1);
    issue(CMD_MOV, 3'd5, 3'd0, 32'd7, 1'b1);
    issue(CMD_DIV, 3'd5, 3'd0, 32'd100, 1'b1);
  endtask

  // Back-to-back commands, each response checked on the following cycle
  task automatic random_stream();
    cmd_e              c;
    logic [AW-1:0]     d;
    logic [AW-1:0]     s;
    logic [31:0]       im;
    logic              ui;
    logic [31:0]       exp_r [STREAM_N];
    logic              exp_w [STREAM_N];
    logic [STAT_W-1:0] exp_s [STREAM_N];
    logic              exp_c [STREAM_N];
    for (int i = 0; i <= STREAM_N; i++) begin
      @(posedge clk);
      if (i < STREAM_N) begin
        c = cmd_e'(5'(rand_bits(5) % 21));
        d = AW'(rand_bits(AW));
        s = AW'(rand_bits(AW));
        ui = rand_bits(1) == 32'd1;
        if (rand_bits(2) == 32'd0) begin
          im = rand_bits(6);
        end else begin
          im = rand_bits(32);
        end
        run_model(c, d, s, im, ui, exp_r[i], exp_w[i], exp_s[i], exp_c[i]);
        cmd_valid <= 1'b1;
        cmd       <= c;
        dst       <= d;
        src       <= s;
        imm       <= im;
        use_imm   <= ui;
      end else begin
        cmd_valid <= 1'b0;
      end
      @(negedge clk);
      if (i > 0) begin
        compare("stream done", 32'(done), 32'd1);
        check_response("stream", exp_r[i-1], exp_w[i-1], exp_s[i-1], exp_c[i-1]);
      end
    end
  endtask

  task automatic direction_and_stream();
    issue(CMD_STD, 3'd0, 3'd0, 32'd0, 1'b1);
    issue(CMD_CLD, 3'd1, 3'd2, 32'd0, 1'b0);
    issue(CMD_STD, 3'd3, 3'd0, 32'd0, 1'b1);
    random_stream();
    issue(CMD_CLD, 3'd0, 3'd0, 32'd0, 1'b1);
  endtask

  task automatic reset_mid_stream();
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd       <= CMD_MOV;
    dst       <= 3'd2;
    imm       <= 32'hDEAD_BEEF;
    use_imm   <= 1'b1;
    @(posedge clk);
    cmd <= CMD_ADD;
    imm <= 32'd1;
    @(posedge clk);
    // Reset lands right after the second command is taken
    arst_n    <= 1'b0;
    cmd_valid <= 1'b0;
    reset_model();
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      compare("done in reset", 32'(done), 32'd0);
      compare("wr in reset", 32'(wr), 32'd0);
      compare("status in reset", 32'(status), 32'd0);
    end
    @(posedge clk);
    arst_n <= 1'b1;
    for (int i = 0; i < 2; i++) begin
      @(negedge clk);
      compare("done after reset", 32'(done), 32'd0);
      compare("wr after reset", 32'(wr), 32'd0);
      compare("status after reset", 32'(status), 32'd0);
    end
    issue(CMD_MOV, 3'd5, 3'd2, 32'h1111_1111, 1'b0);
    issue(CMD_ADD, 3'd5, 3'd3, 32'd0, 1'b0);
  endtask

  initial begin
    arst_n     = 1'b0;
    cmd_valid  = 1'b0;
    cmd        = CMD_MOV;
    dst        = '0;
    src        = '0;
    imm        = '0;
    use_imm    = 1'b0;
    lfsr_state = 32'd51;
    checks     = 0;
    errors     = 0;
    reset_model();
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;

    add_sub_flags();
    carry_and_compare();
    inc_dec_logic();
    shift_mul_div();
    direction_and_stream();
    reset_mid_stream();

    @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- exec_unit.f
hdl/cpu_pkg.sv
hdl/cmd_decode.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/execute.sv
hdl/exec_unit.sv
tests/tb_exec_unit.sv

//--- Makefile
# Verilator flow for the integer execute subsystem

VERILATOR ?= verilator
TOP       ?= tb_exec_unit
RTL_TOP   ?= exec_unit
FILELIST  ?= exec_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
	  --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
	  echo "Simulation FAILED, see $(LOG)"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
